/* filelist.f */
+incdir+src
+incdir+testbench
src/risk_pkg.sv
src/risk_decoder.sv
src/risk_regfile.sv
src/risk_alu.sv
src/risk_sequencer.sv
src/risk_core.sv
testbench/tb_risk_core.sv

/* Bender.yml */
package:
  name: risk_core

export_include_dirs:
  - src

sources:
  - files:
      - src/risk_pkg.sv
      - src/risk_decoder.sv
      - src/risk_regfile.sv
      - src/risk_alu.sv
      - src/risk_sequencer.sv
      - src/risk_core.sv
  - target: test
    include_dirs:
      - src
      - testbench
    files:
      - testbench/tb_risk_core.sv

/* testbench/risk_ref_model.svh */
`ifndef RISK_REF_MODEL_SVH
`define RISK_REF_MODEL_SVH

word_t model_regs [0:(1 << `RISK_REG_AW)-1];   // Entry 0 never written

task automatic clear_model_regs();
    foreach (model_regs[i])
        model_regs[i] = '0;
endtask

// RV32I OP and OP-IMM result by funct3 with alt picking SUB or SRA
function automatic word_t alu_value(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return word_t'($signed(a) < $signed(b));
        3'd3:    return word_t'(a < b);
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic predict(input word_t instr, input word_t pc, output word_t result,
                       output logic wb, output reg_addr_t rd, output word_t next_pc,
                       output logic illegal, output logic has_result);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    logic       taken;
    opcode     = instr[6:0];
    f3         = instr[14:12];
    f7         = instr[31:25];
    rd         = instr[11:7];
    a          = model_regs[instr[19:15]];
    b          = model_regs[instr[24:20]];
    imm_i      = {{20{instr[31]}}, instr[31:20]};
    result     = '0;
    illegal    = 1'b0;
    has_result = 1'b1;
    taken      = 1'b0;
    next_pc    = pc + 32'd4;
    case (opcode)
        7'b0110011: begin
            if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                result = alu_value(f3, f7[5], a, b);
            else
                illegal = 1'b1;   // Includes M extension
        end
        7'b0010011: begin
            if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
                illegal = 1'b1;
            else
                result = alu_value(f3, f3 == 3'd5 && f7[5], a, imm_i);
        end
        7'b0110111: result = {instr[31:12], 12'b0};
        7'b0010111: result = pc + {instr[31:12], 12'b0};
        7'b1101111: begin
            result  = pc + 32'd4;
            next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end
        7'b1100111: begin
            if (f3 != 3'd0) begin
                illegal = 1'b1;
            end else begin
                result  = pc + 32'd4;
                next_pc = a + imm_i;
                next_pc[0] = 1'b0;
            end
        end
        7'b1100011: begin
            has_result = 1'b0;
            case (f3)
                3'd0:    taken = (a == b);
                3'd1:    taken = (a != b);
                3'd4:    taken = ($signed(a) < $signed(b));
                3'd5:    taken = ($signed(a) >= $signed(b));
                3'd6:    taken = (a < b);
                3'd7:    taken = (a >= b);
                default: illegal = 1'b1;
            endcase
            if (taken && !illegal)
                next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
        default: illegal = 1'b1;   // Loads, stores, fences, system, unknown
    endcase
    if (illegal)
        has_result = 1'b0;
    wb = has_result && (rd != '0);
    if (wb)
        model_regs[rd] = result;
endtask

`endif

/* testbench/tb_risk_core.sv */
`timescale 1ns/10ps
`include "risk_settings.svh"

module tb_risk_core;

    import risk_pkg::*;

    `include "risk_ref_model.svh"

    localparam int NUM_ZERO_READS = 1 << `RISK_REG_AW;
    localparam int NUM_RANDOM     = 400;
    localparam int MAX_CYCLES     = (NUM_ZERO_READS + NUM_RANDOM) * 12 + 10;
    localparam int DRIVE_DELAY    = 2;

    logic      i_clk;
    logic      i_arst_n;
    logic      i_req;
    word_t     i_instr;
    word_t     i_pc;
    logic      o_ack;
    logic      o_wb;
    reg_addr_t o_rd;
    word_t     o_result;
    word_t     o_next_pc;
    logic      o_illegal;
    integer    seed = 78591;
    int        cycles = 0;

    risk_core dut (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_req     (i_req),
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .o_ack     (o_ack),
        .o_wb      (o_wb),
        .o_rd      (o_rd),
        .o_result  (o_result),
        .o_next_pc (o_next_pc),
        .o_illegal (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout, run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #DRIVE_DELAY;
    endtask

    // Branches and illegal encodings have no defined result
    task automatic compare_response(input word_t result, input logic wb, input reg_addr_t rd,
                                    input word_t next_pc, input logic illegal,
                                    input logic has_result);
        check_flag("o_ack", o_ack, 1'b1);
        check_flag("o_wb", o_wb, wb);
        check_flag("o_illegal", o_illegal, illegal);
        check_addr("o_rd", o_rd, rd);
        check_word("o_next_pc", o_next_pc, next_pc);
        if (has_result)
            check_word("o_result", o_result, result);
    endtask

    task automatic run_instr(input word_t instr, input word_t pc);
        word_t     exp_result;
        word_t     exp_next_pc;
        reg_addr_t exp_rd;
        logic      exp_wb;
        logic      exp_illegal;
        logic      has_result;
        int        hold;
        predict(instr, pc, exp_result, exp_wb, exp_rd, exp_next_pc, exp_illegal, has_result);
        i_req   = 1'b1;
        i_instr = instr;
        i_pc    = pc;
        do next_cycle(); while (!o_ack);
        compare_response(exp_result, exp_wb, exp_rd, exp_next_pc, exp_illegal, has_result);
        hold = $unsigned($random(seed)) % 5;
        repeat (hold) begin
            next_cycle();
            compare_response(exp_result, exp_wb, exp_rd, exp_next_pc, exp_illegal, has_result);
        end
        i_req = 1'b0;
        do next_cycle(); while (o_ack);
    endtask

    function automatic word_t random_instr();
        word_t      bits;
        word_t      sel;
        logic [2:0] f3;
        logic [6:0] f7;
        bits = $random(seed);
        sel  = $random(seed);
        f3   = sel[6:4];
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && sel[7]) ? 7'h20 : 7'h00;
        case (sel[3:0])
            4'd0, 4'd1, 4'd2, 4'd14:
                return {f7, bits[24:15], f3, bits[11:7], 7'b0110011};
            4'd3, 4'd4, 4'd5, 4'd15: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    return {f7, bits[24:15], f3, bits[11:7], 7'b0010011};
                return {bits[31:15], f3, bits[11:7], 7'b0010011};
            end
            4'd6, 4'd7: return {bits[31:7], 7'b0110111};
            4'd8:       return {bits[31:7], 7'b0010111};
            4'd9, 4'd10: begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;   // Skip reserved funct3
                if (sel[9])
                    bits[24:20] = bits[19:15];   // Equal operands now and then
                return {bits[31:15], f3, bits[11:7], 7'b1100011};
            end
            4'd11: return {bits[31:7], 7'b1101111};
            4'd12: return {bits[31:15], 3'b000, bits[11:7], 7'b1100111};
            default: begin
                case (sel[8:7])
                    2'd0:    return {bits[31:15], f3, bits[11:7], 7'b0000011};
                    2'd1:    return {bits[31:15], f3, bits[11:7], 7'b0100011};
                    2'd2:    return {7'b0000001, bits[24:15], f3, bits[11:7], 7'b0110011};
                    default: return {bits[31:7], 7'b1111111};
                endcase
            end
        endcase
    endfunction

    initial begin
        word_t pc;
        i_arst_n = 1'b0;
        i_req    = 1'b0;
        i_instr  = '0;
        i_pc     = '0;
        clear_model_regs();
        repeat (3) @(posedge i_clk);
        #DRIVE_DELAY;
        i_arst_n = 1'b1;
        next_cycle();
        check_flag("o_ack", o_ack, 1'b0);
        check_flag("o_wb", o_wb, 1'b0);
        check_flag("o_illegal", o_illegal, 1'b0);

        // add x0, xi, x0 reads every register
        for (int i = 0; i < NUM_ZERO_READS; i++) begin
            pc = $random(seed);
            run_instr({12'b0, 5'(i), 3'b000, 5'd0, 7'b0110011}, {pc[31:2], 2'b00});
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            pc = $random(seed);
            run_instr(random_instr(), {pc[31:2], 2'b00});
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* src/risk_core.sv */
`timescale 1ns/10ps

module risk_core (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_req,
    input  risk_pkg::word_t     i_instr,
    input  risk_pkg::word_t     i_pc,
    output logic                o_ack,
    output logic                o_wb,
    output risk_pkg::reg_addr_t o_rd,
    output risk_pkg::word_t     o_result,
    output risk_pkg::word_t     o_next_pc,
    output logic                o_illegal
);

    import risk_pkg::*;

    word_t     instr;
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    logic      cmp_en;
    cmp_op_e   cmp_op;
    logic      cmp_unsigned;
    logic      wb_en;
    logic      jal;
    logic      jalr;
    logic      illegal;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    logic      taken;
    logic      wr_en;
    word_t     wr_data;

    risk_sequencer u_sequencer (
        .i_clk        (i_clk),      .i_arst_n     (i_arst_n),
        .i_req        (i_req),      .i_instr      (i_instr),
        .i_pc         (i_pc),       .i_rd         (rd),
        .i_wb_en      (wb_en),      .i_jal        (jal),
        .i_jalr       (jalr),       .i_illegal    (illegal),
        .i_taken      (taken),      .i_alu_result (alu_result),
        .i_imm        (imm),        .o_instr      (instr),
        .o_pc         (pc),         .o_wr_en      (wr_en),
        .o_wr_data    (wr_data),    .o_ack        (o_ack),
        .o_wb         (o_wb),       .o_rd         (o_rd),
        .o_result     (o_result),   .o_next_pc    (o_next_pc),
        .o_illegal    (o_illegal)
    );

    risk_decoder u_decoder (
        .i_instr        (instr),        .o_rs1          (rs1),
        .o_rs2          (rs2),          .o_rd           (rd),
        .o_imm          (imm),          .o_alu_op       (alu_op),
        .o_op1_sel      (op1_sel),      .o_op2_sel      (op2_sel),
        .o_cmp_en       (cmp_en),       .o_cmp_op       (cmp_op),
        .o_cmp_unsigned (cmp_unsigned), .o_wb_en        (wb_en),
        .o_jal          (jal),          .o_jalr         (jalr),
        .o_illegal      (illegal)
    );

    // Write address comes straight from the latched instruction
    risk_regfile u_regfile (
        .i_clk      (i_clk),    .i_arst_n   (i_arst_n),
        .i_rs1      (rs1),      .i_rs2      (rs2),
        .i_wr_addr  (rd),       .i_wr_en    (wr_en),
        .i_wr_data  (wr_data),  .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    risk_alu u_alu (
        .i_rs1_data     (rs1_data),     .i_rs2_data     (rs2_data),
        .i_imm          (imm),          .i_pc           (pc),
        .i_op           (alu_op),       .i_op1_sel      (op1_sel),
        .i_op2_sel      (op2_sel),      .i_cmp_en       (cmp_en),
        .i_cmp_unsigned (cmp_unsigned), .i_cmp_op       (cmp_op),
        .o_result       (alu_result),   .o_taken        (taken)
    );

endmodule

/* src/risk_sequencer.sv */
`timescale 1ns/10ps

module risk_sequencer (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_req,
    input  risk_pkg::word_t     i_instr,
    input  risk_pkg::word_t     i_pc,
    input  risk_pkg::reg_addr_t i_rd,
    input  logic                i_wb_en,
    input  logic                i_jal,
    input  logic                i_jalr,
    input  logic                i_illegal,
    input  logic                i_taken,
    input  risk_pkg::word_t     i_alu_result,
    input  risk_pkg::word_t     i_imm,
    output risk_pkg::word_t     o_instr,
    output risk_pkg::word_t     o_pc,
    output logic                o_wr_en,
    output risk_pkg::word_t     o_wr_data,
    output logic                o_ack,
    output logic                o_wb,
    output risk_pkg::reg_addr_t o_rd,
    output risk_pkg::word_t     o_result,
    output risk_pkg::word_t     o_next_pc,
    output logic                o_illegal
);

    import risk_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    word_t      link;
    word_t      next_pc;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (i_req)
                    state_d = SEQ_EXEC;
            end
            SEQ_EXEC: state_d = SEQ_ACK;
            SEQ_ACK: begin
                if (!i_req)
                    state_d = SEQ_IDLE;
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    assign link      = o_pc + 32'd4;
    assign o_wr_data = (i_jal || i_jalr) ? link : i_alu_result;
    assign o_wr_en   = (state_q == SEQ_EXEC) && i_wb_en;
    assign o_ack     = (state_q == SEQ_ACK);

    always_comb begin
        if (i_illegal)
            next_pc = link;
        else if (i_jalr)
            next_pc = {i_alu_result[31:1], 1'b0};
        else if (i_jal || i_taken)
            next_pc = o_pc + i_imm;
        else
            next_pc = link;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= SEQ_IDLE;
            o_instr   <= '0;   // All-zero word decodes as illegal
            o_pc      <= '0;
            o_wb      <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == SEQ_IDLE && i_req) begin
                o_instr <= i_instr;
                o_pc    <= i_pc;
            end
            if (state_q == SEQ_EXEC) begin
                o_wb      <= o_wr_en;
                o_illegal <= i_illegal;
            end
        end
    end

    // Response payload valid from ACK on
    always_ff @(posedge i_clk) begin
        if (state_q == SEQ_EXEC) begin
            o_rd      <= i_rd;
            o_result  <= o_wr_data;
            o_next_pc <= next_pc;
        end
    end

    // Request still high at the edge that raised ack
    assert property (@(posedge i_clk) disable iff (!i_arst_n) $rose(o_ack) |-> $past(i_req))
        else $error("ack raised without a pending request");

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_ack && $past(o_ack) |-> $stable({o_result, o_next_pc, o_rd, o_wb, o_illegal}))
        else $error("response changed while ack high");

endmodule

/* src/risk_alu.sv */
`timescale 1ns/10ps

module risk_alu (
    input  risk_pkg::word_t    i_rs1_data,
    input  risk_pkg::word_t    i_rs2_data,
    input  risk_pkg::word_t    i_imm,
    input  risk_pkg::word_t    i_pc,
    input  risk_pkg::alu_op_e  i_op,
    input  risk_pkg::op1_sel_e i_op1_sel,
    input  risk_pkg::op2_sel_e i_op2_sel,
    input  logic               i_cmp_en,
    input  logic               i_cmp_unsigned,
    input  risk_pkg::cmp_op_e  i_cmp_op,
    output risk_pkg::word_t    o_result,
    output logic               o_taken
);

    import risk_pkg::*;

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;
    logic       rs_eq;
    logic       rs_lt;
    logic       cmp_hit;

    always_comb begin
        case (i_op1_sel)
            OP1_PC:   op1 = i_pc;
            OP1_ZERO: op1 = '0;
            default:  op1 = i_rs1_data;
        endcase
    end

    assign op2   = (i_op2_sel == OP2_IMM) ? i_imm : i_rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_op)
            ALU_SUB:  o_result = op1 - op2;
            ALU_XOR:  o_result = op1 ^ op2;
            ALU_OR:   o_result = op1 | op2;
            ALU_AND:  o_result = op1 & op2;
            ALU_SLL:  o_result = op1 << shamt;
            ALU_SRL:  o_result = op1 >> shamt;
            ALU_SRA:  o_result = word_t'($signed(op1) >>> shamt);
            ALU_SLT:  o_result = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: o_result = word_t'(op1 < op2);
            default:  o_result = op1 + op2;
        endcase
    end

    // Branch compare always on the register pair
    assign rs_eq = (i_rs1_data == i_rs2_data);
    assign rs_lt = i_cmp_unsigned ? (i_rs1_data < i_rs2_data)
                                  : ($signed(i_rs1_data) < $signed(i_rs2_data));

    always_comb begin
        case (i_cmp_op)
            CMP_BNE: cmp_hit = !rs_eq;
            CMP_BLT: cmp_hit = rs_lt;
            CMP_BGE: cmp_hit = !rs_lt;
            default: cmp_hit = rs_eq;
        endcase
    end

    assign o_taken = i_cmp_en && cmp_hit;

endmodule

/* src/risk_regfile.sv */
`timescale 1ns/10ps
`include "risk_settings.svh"

module risk_regfile (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  risk_pkg::reg_addr_t i_rs1,
    input  risk_pkg::reg_addr_t i_rs2,
    input  risk_pkg::reg_addr_t i_wr_addr,
    input  logic                i_wr_en,
    input  risk_pkg::word_t     i_wr_data,
    output risk_pkg::word_t     o_rs1_data,
    output risk_pkg::word_t     o_rs2_data
);

    import risk_pkg::*;

    localparam int NUM_REGS = 1 << `RISK_REG_AW;

    word_t regs_q [1:NUM_REGS-1];   // No storage behind x0

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs_q[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs_q[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs_q[i_rs2];

    // Decoder drops rd 0 before the sequencer pulses the write
    assert property (@(posedge i_clk) disable iff (!i_arst_n) i_wr_en |-> i_wr_addr != '0)
        else $error("register file write targets x0");

endmodule

/* src/risk_decoder.sv */
`timescale 1ns/10ps

module risk_decoder (
    input  risk_pkg::word_t     i_instr,
    output risk_pkg::reg_addr_t o_rs1,
    output risk_pkg::reg_addr_t o_rs2,
    output risk_pkg::reg_addr_t o_rd,
    output risk_pkg::word_t     o_imm,
    output risk_pkg::alu_op_e   o_alu_op,
    output risk_pkg::op1_sel_e  o_op1_sel,
    output risk_pkg::op2_sel_e  o_op2_sel,
    output logic                o_cmp_en,
    output risk_pkg::cmp_op_e   o_cmp_op,
    output logic                o_cmp_unsigned,
    output logic                o_wb_en,
    output logic                o_jal,
    output logic                o_jalr,
    output logic                o_illegal
);

    import risk_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB, SRA

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wb_req;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rd   = i_instr[11:7];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: o_imm = imm_u;
            OPC_JAL:            o_imm = imm_j;
            OPC_BRANCH:         o_imm = imm_b;
            OPC_STORE:          o_imm = imm_s;
            default:            o_imm = imm_i;
        endcase
    end

    // Every ALU setting here also requests a write-back
    task automatic set_alu(input alu_op_e op, input op1_sel_e op1, input op2_sel_e op2);
        o_alu_op  = op;
        o_op1_sel = op1;
        o_op2_sel = op2;
        wb_req    = 1'b1;
    endtask

    task automatic set_cmp(input cmp_op_e op, input logic is_unsigned);
        o_cmp_en       = 1'b1;
        o_cmp_op       = op;
        o_cmp_unsigned = is_unsigned;
    endtask

    always_comb begin
        o_alu_op       = ALU_ADD;
        o_op1_sel      = OP1_REG;
        o_op2_sel      = OP2_REG;
        o_cmp_en       = 1'b0;
        o_cmp_op       = CMP_BEQ;
        o_cmp_unsigned = 1'b0;
        o_jal          = 1'b0;
        o_jalr         = 1'b0;
        o_illegal      = 1'b0;
        wb_req         = 1'b0;

        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000:  set_alu(ALU_ADD,  OP1_REG, OP2_REG);
                        3'b001:  set_alu(ALU_SLL,  OP1_REG, OP2_REG);
                        3'b010:  set_alu(ALU_SLT,  OP1_REG, OP2_REG);
                        3'b011:  set_alu(ALU_SLTU, OP1_REG, OP2_REG);
                        3'b100:  set_alu(ALU_XOR,  OP1_REG, OP2_REG);
                        3'b101:  set_alu(ALU_SRL,  OP1_REG, OP2_REG);
                        3'b110:  set_alu(ALU_OR,   OP1_REG, OP2_REG);
                        default: set_alu(ALU_AND,  OP1_REG, OP2_REG);
                    endcase
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    set_alu(ALU_SUB, OP1_REG, OP2_REG);
                end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
                    set_alu(ALU_SRA, OP1_REG, OP2_REG);
                end else begin
                    o_illegal = 1'b1;   // M extension ends up here
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: set_alu(ALU_ADD,  OP1_REG, OP2_IMM);
                    3'b010: set_alu(ALU_SLT,  OP1_REG, OP2_IMM);
                    3'b011: set_alu(ALU_SLTU, OP1_REG, OP2_IMM);
                    3'b100: set_alu(ALU_XOR,  OP1_REG, OP2_IMM);
                    3'b110: set_alu(ALU_OR,   OP1_REG, OP2_IMM);
                    3'b111: set_alu(ALU_AND,  OP1_REG, OP2_IMM);
                    3'b001: begin
                        if (funct7 == F7_BASE)
                            set_alu(ALU_SLL, OP1_REG, OP2_IMM);
                        else
                            o_illegal = 1'b1;
                    end
                    default: begin
                        if (funct7 == F7_BASE)
                            set_alu(ALU_SRL, OP1_REG, OP2_IMM);
                        else if (funct7 == F7_ALT)
                            set_alu(ALU_SRA, OP1_REG, OP2_IMM);
                        else
                            o_illegal = 1'b1;
                    end
                endcase
            end
            OPC_LUI:   set_alu(ALU_ADD, OP1_ZERO, OP2_IMM);
            OPC_AUIPC: set_alu(ALU_ADD, OP1_PC, OP2_IMM);
            OPC_JAL: begin
                set_alu(ALU_ADD, OP1_PC, OP2_IMM);
                o_jal = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    set_alu(ALU_ADD, OP1_REG, OP2_IMM);   // Target before bit 0 clear
                    o_jalr = 1'b1;
                end else begin
                    o_illegal = 1'b1;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  set_cmp(CMP_BEQ, 1'b0);
                    3'b001:  set_cmp(CMP_BNE, 1'b0);
                    3'b100:  set_cmp(CMP_BLT, 1'b0);
                    3'b101:  set_cmp(CMP_BGE, 1'b0);
                    3'b110:  set_cmp(CMP_BLT, 1'b1);
                    3'b111:  set_cmp(CMP_BGE, 1'b1);
                    default: o_illegal = 1'b1;
                endcase
            end
            // Loads, stores, fences, system
            default: o_illegal = 1'b1;
        endcase

        o_wb_en = wb_req && !o_illegal && (o_rd != '0);
    end

endmodule

/* src/risk_pkg.sv */
`include "risk_settings.svh"

package risk_pkg;

    typedef logic [`RISK_XLEN-1:0]   word_t;
    typedef logic [`RISK_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // ZERO serves LUI as operand 1
    typedef enum logic [1:0] {
        OP1_REG,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        CMP_BEQ,
        CMP_BNE,
        CMP_BLT,
        CMP_BGE   // Unsigned variants via separate flag
    } cmp_op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_EXEC,
        SEQ_ACK
    } seq_state_e;

endpackage

/* src/risk_settings.svh */
`ifndef RISK_SETTINGS_SVH
`define RISK_SETTINGS_SVH

// Data path width
`define RISK_XLEN 32

// Register index width for 32 registers
`define RISK_REG_AW 5

`endif
